/* list.f */
sq_pkg.sv
sq_apb_regs.sv
sq_frame_seq.sv
sq_sweep.sv
sq_timer_duty.sv
sq_envelope.sv
sq_channel.sv
sq_apu_top.sv
tb_sq_apu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the pulse channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sq_apu \
	-f list.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, pass message not found in $LOG"
exit 1

/* sq_apb_regs.sv */
// ======================================================================
// APB slave for the pulse channels. Decodes writes into per-channel
// strobes, keeps the channel enables and returns live state on reads.
// ======================================================================
`timescale 1ns/1ps

module sq_apb_regs (
	input  logic                      aclk,
	input  logic                      rst,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [sq_pkg::ADDR_W-1:0] paddr,
	input  logic [7:0]                pwdata,
	output logic [7:0]                prdata,
	output logic                      pready,
	output logic                      pslverr,
	output logic [1:0]                wr_ctrl,
	output logic [1:0]                wr_sweep,
	output logic [1:0]                wr_tlo,
	output logic [1:0]                wr_thi,
	output logic [7:0]                wdata,
	output logic [1:0]                ch_en,
	input  logic [sq_pkg::PERIOD_W-1:0] period0,
	input  logic [sq_pkg::PERIOD_W-1:0] period1,
	input  logic [1:0]                len_active
);
	import sq_pkg::*;

	logic access;
	logic ch_sel;
	logic ch_wr;
	logic is_status;
	sq_reg_e reg_sel;
	logic [PERIOD_W-1:0] period_sel;

	assign access = psel & penable;
	assign ch_sel = paddr[2];
	assign reg_sel = sq_reg_e'(paddr[1:0]);
	assign is_status = (paddr == ADDR_STATUS);
	assign ch_wr = access & pwrite & (paddr < ADDR_STATUS);
	assign period_sel = ch_sel ? period1 : period0;

	assign pready = 1'b1;	// No wait states
	assign pslverr = access & (paddr > ADDR_STATUS);
	assign wdata = pwdata;

	always_comb begin
		wr_ctrl = '0;
		wr_sweep = '0;
		wr_tlo = '0;
		wr_thi = '0;
		if (ch_wr) begin
			case (reg_sel)
				REG_CTRL:  wr_ctrl[ch_sel] = 1'b1;
				REG_SWEEP: wr_sweep[ch_sel] = 1'b1;
				REG_TLO:   wr_tlo[ch_sel] = 1'b1;
				REG_THI:   wr_thi[ch_sel] = 1'b1;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (rst) begin
			ch_en <= '0;
		end else if (access && pwrite && is_status) begin
			ch_en <= pwdata[1:0];
		end
	end

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (is_status) begin
				prdata = {6'd0, len_active};
			end else if (paddr < ADDR_STATUS) begin
				case (reg_sel)
					REG_TLO: prdata = period_sel[7:0];
					REG_THI: prdata = {5'd0, period_sel[10:8]};
					default: prdata = '0;	// Control and sweep are write-only
				endcase
			end
		end
	end

endmodule

/* sq_apu_top.sv */
// ======================================================================
// Top level of the pulse pair: APB register block, frame sequencer
// and two channels differing only in sweep negate mode.
// ======================================================================
`timescale 1ns/1ps

module sq_apu_top (
	input  logic                      aclk,
	input  logic                      rst,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [sq_pkg::ADDR_W-1:0] paddr,
	input  logic [7:0]                pwdata,
	output logic [7:0]                prdata,
	output logic                      pready,
	output logic                      pslverr,
	output logic [3:0]                sq0_out,
	output logic [3:0]                sq1_out
);
	import sq_pkg::*;

	logic [1:0] wr_ctrl;
	logic [1:0] wr_sweep;
	logic [1:0] wr_tlo;
	logic [1:0] wr_thi;
	logic [7:0] wdata;
	logic [1:0] ch_en;
	logic [1:0] len_active;
	logic [PERIOD_W-1:0] period0;
	logic [PERIOD_W-1:0] period1;
	logic quarter_tick;
	logic half_tick;

	sq_apb_regs i_sq_apb_regs (
		.aclk       (aclk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.wr_ctrl    (wr_ctrl),
		.wr_sweep   (wr_sweep),
		.wr_tlo     (wr_tlo),
		.wr_thi     (wr_thi),
		.wdata      (wdata),
		.ch_en      (ch_en),
		.period0    (period0),
		.period1    (period1),
		.len_active (len_active)
	);

	sq_frame_seq i_sq_frame_seq (
		.aclk         (aclk),
		.rst          (rst),
		.quarter_tick (quarter_tick),
		.half_tick    (half_tick)
	);

	// Channel 0 negates in ones' complement
	sq_channel #(
		.NEG_ONES(1'b1)
	) i_sq_channel0 (
		.aclk         (aclk),
		.rst          (rst),
		.wr_ctrl      (wr_ctrl[0]),
		.wr_sweep     (wr_sweep[0]),
		.wr_tlo       (wr_tlo[0]),
		.wr_thi       (wr_thi[0]),
		.wdata        (wdata),
		.ch_en        (ch_en[0]),
		.quarter_tick (quarter_tick),
		.half_tick    (half_tick),
		.period       (period0),
		.len_active   (len_active[0]),
		.sq_out       (sq0_out)
	);

	sq_channel #(
		.NEG_ONES(1'b0)
	) i_sq_channel1 (
		.aclk         (aclk),
		.rst          (rst),
		.wr_ctrl      (wr_ctrl[1]),
		.wr_sweep     (wr_sweep[1]),
		.wr_tlo       (wr_tlo[1]),
		.wr_thi       (wr_thi[1]),
		.wdata        (wdata),
		.ch_en        (ch_en[1]),
		.quarter_tick (quarter_tick),
		.half_tick    (half_tick),
		.period       (period1),
		.len_active   (len_active[1]),
		.sq_out       (sq1_out)
	);

endmodule

/* sq_channel.sv */
// ======================================================================
// One pulse channel: sweep, timer/duty and envelope stages feeding a
// registered 4-bit output sample.
// ======================================================================
`timescale 1ns/1ps

module sq_channel #(
	parameter bit NEG_ONES = 1'b0
) (
	input  logic                        aclk,
	input  logic                        rst,
	input  logic                        wr_ctrl,
	input  logic                        wr_sweep,
	input  logic                        wr_tlo,
	input  logic                        wr_thi,
	input  logic [7:0]                  wdata,
	input  logic                        ch_en,
	input  logic                        quarter_tick,
	input  logic                        half_tick,
	output logic [sq_pkg::PERIOD_W-1:0] period,
	output logic                        len_active,
	output logic [3:0]                  sq_out
);

	logic [1:0] duty;
	logic mute;
	logic duty_bit;
	logic [3:0] volume;

	sq_sweep #(
		.NEG_ONES(NEG_ONES)
	) i_sq_sweep (
		.aclk      (aclk),
		.rst       (rst),
		.wr_sweep  (wr_sweep),
		.wr_tlo    (wr_tlo),
		.wr_thi    (wr_thi),
		.wdata     (wdata),
		.half_tick (half_tick),
		.period    (period),
		.mute      (mute)
	);

	sq_timer_duty i_sq_timer_duty (
		.aclk     (aclk),
		.rst      (rst),
		.period   (period),
		.duty     (duty),
		.wr_thi   (wr_thi),
		.duty_bit (duty_bit)
	);

	sq_envelope i_sq_envelope (
		.aclk         (aclk),
		.rst          (rst),
		.wr_ctrl      (wr_ctrl),
		.wr_thi       (wr_thi),
		.wdata        (wdata),
		.ch_en        (ch_en),
		.quarter_tick (quarter_tick),
		.half_tick    (half_tick),
		.volume       (volume),
		.len_active   (len_active)
	);

	always_ff @(posedge aclk) begin
		if (rst) begin
			duty <= '0;
		end else if (wr_ctrl) begin
			duty <= wdata[7:6];
		end
	end

	// Output gate
	always_ff @(posedge aclk) begin
		if (rst) begin
			sq_out <= '0;
		end else if (duty_bit && !mute && len_active) begin
			sq_out <= volume;
		end else begin
			sq_out <= '0;
		end
	end

endmodule

/* sq_envelope.sv */
// ======================================================================
// Envelope generator and length counter of one channel, clocked by
// the frame ticks and the control and timer-high writes.
// ======================================================================
`timescale 1ns/1ps

module sq_envelope (
	input  logic       aclk,
	input  logic       rst,
	input  logic       wr_ctrl,
	input  logic       wr_thi,
	input  logic [7:0] wdata,
	input  logic       ch_en,
	input  logic       quarter_tick,
	input  logic       half_tick,
	output logic [3:0] volume,
	output logic       len_active
);
	import sq_pkg::*;

	logic halt;
	logic const_vol;
	logic [3:0] vol;
	logic start;
	logic [3:0] decay;
	logic [3:0] div;
	logic [7:0] length;

	assign volume = const_vol ? vol : decay;
	assign len_active = (length != '0);

	always_ff @(posedge aclk) begin
		if (rst) begin
			halt <= 1'b0;
			const_vol <= 1'b0;
			vol <= '0;
			start <= 1'b0;
			decay <= '0;
			div <= '0;
			length <= '0;
		end else begin
			if (quarter_tick) begin
				if (start) begin
					start <= 1'b0;
					decay <= 4'd15;
					div <= vol;
				end else if (div == '0) begin
					div <= vol;
					if (decay != '0) begin
						decay <= decay - 1'b1;
					end else if (halt) begin
						decay <= 4'd15;	// Loop envelope
					end
				end else begin
					div <= div - 1'b1;
				end
			end

			if (half_tick && len_active && !halt) begin
				length <= length - 1'b1;
			end

			if (wr_ctrl) begin
				halt <= wdata[5];
				const_vol <= wdata[4];
				vol <= wdata[3:0];
			end

			if (wr_thi) begin
				start <= 1'b1;
				if (ch_en) begin
					length <= LENGTH_TABLE[wdata[7:3]];
				end
			end

			if (!ch_en) begin
				length <= '0;
			end
		end
	end

endmodule

/* sq_frame_seq.sv */
// ======================================================================
// Frame divider producing quarter-frame and half-frame tick pulses
// for the envelopes, sweeps and length counters.
// ======================================================================
`timescale 1ns/1ps

module sq_frame_seq (
	input  logic aclk,
	input  logic rst,
	output logic quarter_tick,
	output logic half_tick
);
	import sq_pkg::*;

	localparam int CNT_W = $clog2(FRAME_DIV);

	logic [CNT_W-1:0] cnt;
	logic half_phase;

	assign quarter_tick = (cnt == CNT_W'(FRAME_DIV - 1));
	assign half_tick = quarter_tick & half_phase;	// Every second quarter

	always_ff @(posedge aclk) begin
		if (rst) begin
			cnt <= '0;
			half_phase <= 1'b0;
		end else begin
			if (quarter_tick) begin
				cnt <= '0;
				half_phase <= ~half_phase;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

/* sq_pkg.sv */
// ======================================================================
// Shared constants, register opcodes and lookup tables for the pulse
// channels. Modules import it inside their bodies where needed.
// ======================================================================
package sq_pkg;

	localparam int ADDR_W = 5;
	localparam int PERIOD_W = 11;

	localparam logic [ADDR_W-1:0] ADDR_STATUS = 5'd8;

	// Register offset inside a channel window
	typedef enum logic [1:0] {
		REG_CTRL,
		REG_SWEEP,
		REG_TLO,
		REG_THI
	} sq_reg_e;

	// Bit n is the output at sequencer step n
	localparam logic [7:0] DUTY_TABLE [4] = '{
		8'b0000_0010,	// 12.5%
		8'b0000_0110,	// 25%
		8'b0001_1110,	// 50%
		8'b1111_1001	// 75% (inverted 25%)
	};

	// Length index to count
	localparam logic [7:0] LENGTH_TABLE [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	localparam int FRAME_DIV = 64;	// Shortened for simulation
	localparam logic [PERIOD_W-1:0] MIN_PERIOD = 11'd8;

endpackage

/* sq_sweep.sv */
// ======================================================================
// Period register with sweep unit: shifter, adder, divider and mute
// detection. NEG_ONES selects ones' complement negate.
// ======================================================================
`timescale 1ns/1ps

module sq_sweep #(
	parameter bit NEG_ONES = 1'b0
) (
	input  logic                        aclk,
	input  logic                        rst,
	input  logic                        wr_sweep,
	input  logic                        wr_tlo,
	input  logic                        wr_thi,
	input  logic [7:0]                  wdata,
	input  logic                        half_tick,
	output logic [sq_pkg::PERIOD_W-1:0] period,
	output logic                        mute
);
	import sq_pkg::*;

	logic sw_en;
	logic [2:0] sw_per;
	logic sw_neg;
	logic [2:0] sw_shift;
	logic [2:0] div;
	logic reload;
	logic [PERIOD_W-1:0] shifted;
	logic [PERIOD_W:0] target;	// Extra bit flags overflow
	logic do_sweep;

	assign shifted = period >> sw_shift;

	always_comb begin
		if (sw_neg) begin
			target = {1'b0, period} - {1'b0, shifted} - {{PERIOD_W{1'b0}}, NEG_ONES};
		end else begin
			target = {1'b0, period} + {1'b0, shifted};
		end
	end

	assign mute = (period < MIN_PERIOD) || (!sw_neg && target[PERIOD_W]);
	assign do_sweep = half_tick && (div == 3'd0) && sw_en && (sw_shift != 3'd0) && !mute;

	always_ff @(posedge aclk) begin
		if (rst) begin
			period <= '0;
			sw_en <= 1'b0;
			sw_per <= '0;
			sw_neg <= 1'b0;
			sw_shift <= '0;
			div <= '0;
			reload <= 1'b0;
		end else begin
			if (wr_tlo) begin
				period[7:0] <= wdata;
			end else if (wr_thi) begin
				period[10:8] <= wdata[2:0];
			end else if (do_sweep) begin
				period <= target[PERIOD_W-1:0];
			end

			if (half_tick) begin
				if (div == 3'd0 || reload) begin
					div <= sw_per;
				end else begin
					div <= div - 1'b1;
				end
				reload <= 1'b0;
			end

			if (wr_sweep) begin
				sw_en <= wdata[7];
				sw_per <= wdata[6:4];
				sw_neg <= wdata[3];
				sw_shift <= wdata[2:0];
				reload <= 1'b1;	// Wins over the tick clear
			end
		end
	end

endmodule

/* sq_timer_duty.sv */
// ======================================================================
// Channel timer and 8-step duty sequencer. The step counter counts
// down once per timer reload and restarts on a timer-high write.
// ======================================================================
`timescale 1ns/1ps

module sq_timer_duty (
	input  logic                        aclk,
	input  logic                        rst,
	input  logic [sq_pkg::PERIOD_W-1:0] period,
	input  logic [1:0]                  duty,
	input  logic                        wr_thi,
	output logic                        duty_bit
);
	import sq_pkg::*;

	logic [PERIOD_W-1:0] cnt;
	logic [2:0] step;
	logic [7:0] pattern;
	logic reload;

	assign reload = (cnt == '0);
	assign pattern = DUTY_TABLE[duty];
	assign duty_bit = pattern[step];

	always_ff @(posedge aclk) begin
		if (rst) begin
			cnt <= '0;
		end else if (reload) begin
			cnt <= period;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// Sequencer steps on each timer reload
	always_ff @(posedge aclk) begin
		if (rst) begin
			step <= '0;
		end else if (wr_thi) begin
			step <= '0;
		end else if (reload) begin
			step <= step - 1'b1;	// Wraps 0 to 7
		end
	end

endmodule

/* tb_sq_apu.sv */
// ======================================================================
// Testbench for the pulse pair. Drives random APB traffic and checks
// both outputs each cycle and every read access against a cycle model.
// ======================================================================
`timescale 1ns/1ps

module tb_sq_apu;
	import sq_pkg::*;

	localparam int NUM_XFER = 400;
	localparam int TIMEOUT_CYCLES = 16 + NUM_XFER * 23 + 100;

	logic aclk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic pslverr;
	logic [3:0] sq0_out;
	logic [3:0] sq1_out;

	// Reference model state per channel
	logic [10:0] m_period [2];
	logic m_sw_en [2];
	logic [2:0] m_sw_per [2];
	logic m_sw_neg [2];
	logic [2:0] m_sw_shift [2];
	logic [2:0] m_sdiv [2];
	logic m_reload [2];
	logic [10:0] m_tcnt [2];
	logic [2:0] m_step [2];
	logic [1:0] m_duty [2];
	logic m_halt [2];
	logic m_const [2];
	logic [3:0] m_vol [2];
	logic m_start [2];
	logic [3:0] m_decay [2];
	logic [3:0] m_ediv [2];
	logic [7:0] m_len [2];
	logic [3:0] m_out [2];
	logic [1:0] m_ch_en;
	int m_fcnt;
	logic m_half_phase;
	int cycle_cnt;
	int unsigned seed_ret;

	sq_apu_top i_sq_apu_top (
		.aclk    (aclk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.sq0_out (sq0_out),
		.sq1_out (sq1_out)
	);

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=0x%0h expected=0x%0h",
				$time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "check on %s failed", name);
		end
	endtask

	task automatic reset_model();
		for (int c = 0; c < 2; c++) begin
			m_period[c] = '0;
			m_sw_en[c] = 1'b0;
			m_sw_per[c] = '0;
			m_sw_neg[c] = 1'b0;
			m_sw_shift[c] = '0;
			m_sdiv[c] = '0;
			m_reload[c] = 1'b0;
			m_tcnt[c] = '0;
			m_step[c] = '0;
			m_duty[c] = '0;
			m_halt[c] = 1'b0;
			m_const[c] = 1'b0;
			m_vol[c] = '0;
			m_start[c] = 1'b0;
			m_decay[c] = '0;
			m_ediv[c] = '0;
			m_len[c] = '0;
			m_out[c] = '0;
		end
		m_ch_en = '0;
		m_fcnt = 0;
		m_half_phase = 1'b0;
	endtask

	// Next state of one channel from its old state
	task automatic model_channel(input int c, input logic qt, input logic ht,
			input logic wc, input logic ws, input logic wl, input logic wh,
			input logic [7:0] d, input logic en);
		logic [10:0] shifted;
		logic [11:0] target;
		logic mute;
		logic sweep_now;
		logic [7:0] pat;
		logic [3:0] vol_now;
		logic len_act;
		shifted = m_period[c] >> m_sw_shift[c];
		if (m_sw_neg[c]) begin
			target = {1'b0, m_period[c]} - {1'b0, shifted};
			if (c == 0) begin
				target = target - 12'd1;	// Ones' complement negate
			end
		end else begin
			target = {1'b0, m_period[c]} + {1'b0, shifted};
		end
		mute = (m_period[c] < MIN_PERIOD) || (!m_sw_neg[c] && target[11]);
		sweep_now = ht && (m_sdiv[c] == 3'd0) && m_sw_en[c]
			&& (m_sw_shift[c] != 3'd0) && !mute;
		pat = DUTY_TABLE[m_duty[c]];
		vol_now = m_const[c] ? m_vol[c] : m_decay[c];
		len_act = (m_len[c] != 8'd0);
		m_out[c] = (pat[m_step[c]] && !mute && len_act) ? vol_now : 4'd0;

		if (wh) begin
			m_step[c] = 3'd0;
		end else if (m_tcnt[c] == 11'd0) begin
			m_step[c] = m_step[c] - 3'd1;
		end
		if (m_tcnt[c] == 11'd0) begin
			m_tcnt[c] = m_period[c];
		end else begin
			m_tcnt[c] = m_tcnt[c] - 11'd1;
		end

		if (qt) begin
			if (m_start[c]) begin
				m_start[c] = 1'b0;
				m_decay[c] = 4'd15;
				m_ediv[c] = m_vol[c];
			end else if (m_ediv[c] == 4'd0) begin
				m_ediv[c] = m_vol[c];
				if (m_decay[c] != 4'd0) begin
					m_decay[c] = m_decay[c] - 4'd1;
				end else if (m_halt[c]) begin
					m_decay[c] = 4'd15;
				end
			end else begin
				m_ediv[c] = m_ediv[c] - 4'd1;
			end
		end
		if (ht && len_act && !m_halt[c]) begin
			m_len[c] = m_len[c] - 8'd1;
		end
		if (wc) begin
			m_halt[c] = d[5];
			m_const[c] = d[4];
			m_vol[c] = d[3:0];
			m_duty[c] = d[7:6];
		end
		if (wh) begin
			m_start[c] = 1'b1;
			if (en) begin
				m_len[c] = LENGTH_TABLE[d[7:3]];
			end
		end
		if (!en) begin
			m_len[c] = 8'd0;
		end

		if (wl) begin
			m_period[c][7:0] = d;
		end else if (wh) begin
			m_period[c][10:8] = d[2:0];
		end else if (sweep_now) begin
			m_period[c] = target[10:0];
		end
		if (ht) begin
			if (m_sdiv[c] == 3'd0 || m_reload[c]) begin
				m_sdiv[c] = m_sw_per[c];
			end else begin
				m_sdiv[c] = m_sdiv[c] - 3'd1;
			end
			m_reload[c] = 1'b0;
		end
		if (ws) begin
			m_sw_en[c] = d[7];
			m_sw_per[c] = d[6:4];
			m_sw_neg[c] = d[3];
			m_sw_shift[c] = d[2:0];
			m_reload[c] = 1'b1;
		end
	endtask

	task automatic model_step();
		logic access;
		logic qt;
		logic ht;
		logic sel;
		access = psel && penable;
		qt = (m_fcnt == FRAME_DIV - 1);
		ht = qt && m_half_phase;
		for (int c = 0; c < 2; c++) begin
			sel = access && pwrite && (paddr < 5'd8) && (paddr[2] == 1'(c));
			model_channel(c, qt, ht, sel && (paddr[1:0] == REG_CTRL),
				sel && (paddr[1:0] == REG_SWEEP), sel && (paddr[1:0] == REG_TLO),
				sel && (paddr[1:0] == REG_THI), pwdata, m_ch_en[c]);
		end
		if (access && pwrite && paddr == 5'd8) begin
			m_ch_en = pwdata[1:0];
		end
		if (qt) begin
			m_fcnt = 0;
			m_half_phase = ~m_half_phase;
		end else begin
			m_fcnt = m_fcnt + 1;
		end
	endtask

	always @(posedge aclk) begin
		if (rst) begin
			reset_model();
		end else begin
			model_step();
		end
	end

	always @(posedge aclk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("ERROR: simulation did not finish within %0d cycles",
				TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	// Registered outputs are stable at the falling edge
	always @(negedge aclk) begin
		if (!rst) begin
			check_value("sq0_out", 32'(sq0_out), 32'(m_out[0]));
			check_value("sq1_out", 32'(sq1_out), 32'(m_out[1]));
		end
	end

	function automatic logic [7:0] expected_rdata(input logic [4:0] addr);
		logic c;
		c = addr[2];
		if (addr == 5'd8) begin
			return {6'd0, m_len[1] != 8'd0, m_len[0] != 8'd0};
		end
		if (addr > 5'd8) begin
			return 8'd0;
		end
		case (addr[1:0])
			2'd2: return m_period[c][7:0];
			2'd3: return {5'd0, m_period[c][10:8]};
			default: return 8'd0;	// Write-only registers
		endcase
	endfunction

	task automatic apb_xfer(input logic [4:0] addr, input logic wr, input logic [7:0] data);
		@(negedge aclk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(negedge aclk);
		penable = 1'b1;
		#5;
		check_value("pready", 32'(pready), 32'd1);
		check_value("pslverr", 32'(pslverr), 32'(addr > 5'd8));
		if (!wr) begin
			check_value("prdata", 32'(prdata), 32'(expected_rdata(addr)));
		end
	endtask

	// Weighted toward status and timer-high writes
	task automatic pick_transfer(output logic [4:0] addr, output logic wr,
			output logic [7:0] data);
		int unsigned r;
		logic ch;
		r = $urandom_range(15, 0);
		ch = 1'($urandom_range(1, 0));
		data = 8'($urandom);
		wr = 1'b1;
		if (r < 3) begin
			addr = 5'd8;
			if ($urandom_range(3, 0) != 0) begin
				data = 8'h03;
			end
		end else if (r < 6) begin
			addr = {2'b00, ch, 2'b11};
			if ($urandom_range(3, 0) != 0) begin
				data[2:0] = 3'd0;	// Keep periods short
			end
		end else if (r < 8) begin
			addr = {2'b00, ch, 2'b10};
		end else if (r == 8) begin
			addr = {2'b00, ch, 2'b00};
		end else if (r == 9) begin
			addr = {2'b00, ch, 2'b01};
		end else if (r < 13) begin
			addr = 5'($urandom_range(8, 0));
			wr = 1'b0;
		end else if (r == 13) begin
			addr = 5'd8;
			wr = 1'b0;
		end else begin
			addr = 5'($urandom_range(31, 9));
			wr = 1'($urandom_range(1, 0));
		end
	endtask

	initial begin
		logic [4:0] addr;
		logic wr;
		logic [7:0] data;
		int unsigned gap;
		seed_ret = $urandom(32'h370c_7022);
		cycle_cnt = 0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (16) @(negedge aclk);
		rst = 1'b0;
		for (int i = 0; i < NUM_XFER; i++) begin
			pick_transfer(addr, wr, data);
			apb_xfer(addr, wr, data);
			@(negedge aclk);
			psel = 1'b0;
			penable = 1'b0;
			gap = $urandom_range(20, 0);
			repeat (gap) @(negedge aclk);
		end
		repeat (50) @(negedge aclk);
		$display("TB PASSED");
		$finish;
	end

endmodule
